//--- rtl/arrow_pkg.sv
//----------------------------------------------------------------------
// Shared constants, BAR1 address map and AXI4-Lite channel payloads
//----------------------------------------------------------------------
package arrow_pkg;

  // Bus widths
  localparam int axil_addr_w = 32;
  localparam int axil_data_w = 32;
  localparam int axil_strb_w = axil_data_w / 8;

  // AXI4-Lite response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Card identity words
  localparam logic [31:0] cl_sh_id0_val = 32'hF001_1D0F;
  localparam logic [31:0] cl_sh_id1_val = 32'h1D51_FEDC;

  //--------------------------------------------------------------------
  // BAR1 register map
  //--------------------------------------------------------------------
  localparam logic [axil_addr_w-1:0] reg_id0_addr     = 32'h0000_0000;
  localparam logic [axil_addr_w-1:0] reg_id1_addr     = 32'h0000_0004;
  localparam logic [axil_addr_w-1:0] reg_scratch_base = 32'h0000_0010;
  localparam int scratch_count = 4;
  localparam int scratch_idx_w = $clog2(scratch_count);

  // Pre-sync chain length
  localparam int rst_sync_stages = 2;

  // Channel payloads, AR reuses the AW layout
  typedef struct packed {
    logic [axil_addr_w-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [axil_data_w-1:0] data;
    logic [axil_strb_w-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [axil_data_w-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

endpackage

//--- rtl/arrow_rst_sync.sv
//----------------------------------------------------------------------
// Reset pre-sync chain and function-level-reset acknowledge
//----------------------------------------------------------------------
`timescale 1ns/10ps

module arrow_rst_sync
  import arrow_pkg::*;
(
  input  logic clk,
  input  logic pipe_rst_n,
  input  logic flr_assert,
  output logic sync_rst_n,
  output logic flr_done
);

  logic [rst_sync_stages-1:0] rst_chain;
  logic                       flr_assert_q;

  // Ones shift in once pipe_rst_n is released
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
      rst_chain <= '0;
    else
      rst_chain <= {rst_chain[rst_sync_stages-2:0], 1'b1};
  end

  assign sync_rst_n = rst_chain[rst_sync_stages-1];

  //--------------------------------------------------------------------
  // FLR answer
  //--------------------------------------------------------------------
  // A held request makes flr_done toggle, a single-cycle one gives one pulse
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

endmodule

//--- rtl/axil_chan_buf.sv
//----------------------------------------------------------------------
// Two-entry skid buffer for a single AXI4-Lite channel
//----------------------------------------------------------------------
`timescale 1ns/10ps

module axil_chan_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     main_valid, main_valid_nxt;
  logic     skid_valid, skid_valid_nxt;
  logic     main_load, skid_load, in_fire;
  payload_t skid_data;

  assign in_fire = in_valid && in_ready;

  always_comb
  begin
    main_valid_nxt = main_valid;
    skid_valid_nxt = skid_valid;
    main_load      = 1'b0;
    skid_load      = 1'b0;
    if (!main_valid || out_ready)
    begin
      // Output slot frees up, refill from skid first
      main_load      = skid_valid || in_fire;
      main_valid_nxt = skid_valid || in_fire;
      skid_valid_nxt = 1'b0;
    end
    else if (in_fire)
    begin
      skid_load      = 1'b1;
      skid_valid_nxt = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end
    else
    begin
      main_valid <= main_valid_nxt;
      skid_valid <= skid_valid_nxt;
      // Registered ready, drops only with both entries full
      in_ready   <= !skid_valid_nxt;
    end
  end

  always_ff @(posedge clk)
  begin
    if (main_load)
      out_data <= skid_valid ? skid_data : in_data;
    if (skid_load)
      skid_data <= in_data;
  end

  assign out_valid = main_valid;

endmodule

//--- rtl/arrow_bar1_slice.sv
//----------------------------------------------------------------------
// BAR1 AXI4-Lite register slice, request and response buffers
//----------------------------------------------------------------------
`timescale 1ns/10ps

module arrow_bar1_slice
  import arrow_pkg::*;
(
  input  logic                   clk,
  input  logic                   sync_rst_n,
  // Shell side
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [axil_addr_w-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [axil_data_w-1:0] wdata,
  input  logic [axil_strb_w-1:0] wstrb,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [axil_addr_w-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [axil_data_w-1:0] rdata,
  output logic [1:0]             rresp,
  // Register bank side
  output logic                   mmio_awvalid,
  input  logic                   mmio_awready,
  output logic [axil_addr_w-1:0] mmio_awaddr,
  output logic                   mmio_wvalid,
  input  logic                   mmio_wready,
  output logic [axil_data_w-1:0] mmio_wdata,
  output logic [axil_strb_w-1:0] mmio_wstrb,
  input  logic                   mmio_bvalid,
  output logic                   mmio_bready,
  input  logic [1:0]             mmio_bresp,
  output logic                   mmio_arvalid,
  input  logic                   mmio_arready,
  output logic [axil_addr_w-1:0] mmio_araddr,
  input  logic                   mmio_rvalid,
  output logic                   mmio_rready,
  input  logic [axil_data_w-1:0] mmio_rdata,
  input  logic [1:0]             mmio_rresp
);

  axil_aw_t aw_in, aw_out, ar_in, ar_out;
  axil_w_t  w_in, w_out;
  axil_b_t  b_in, b_out;
  axil_r_t  r_in, r_out;

  //--------------------------------------------------------------------
  // Request half, shell to bank
  //--------------------------------------------------------------------
  assign aw_in.addr  = awaddr;
  assign w_in.data   = wdata;
  assign w_in.strb   = wstrb;
  assign ar_in.addr  = araddr;
  assign mmio_awaddr = aw_out.addr;
  assign mmio_wdata  = w_out.data;
  assign mmio_wstrb  = w_out.strb;
  assign mmio_araddr = ar_out.addr;

  axil_chan_buf #(.payload_t(axil_aw_t)) aw_buf_inst (
    .clk       (clk),          .sync_rst_n (sync_rst_n),
    .in_valid  (awvalid),      .in_ready   (awready),      .in_data  (aw_in),
    .out_valid (mmio_awvalid), .out_ready  (mmio_awready), .out_data (aw_out)
  );

  axil_chan_buf #(.payload_t(axil_w_t)) w_buf_inst (
    .clk       (clk),          .sync_rst_n (sync_rst_n),
    .in_valid  (wvalid),       .in_ready   (wready),       .in_data  (w_in),
    .out_valid (mmio_wvalid),  .out_ready  (mmio_wready),  .out_data (w_out)
  );

  axil_chan_buf #(.payload_t(axil_aw_t)) ar_buf_inst (
    .clk       (clk),          .sync_rst_n (sync_rst_n),
    .in_valid  (arvalid),      .in_ready   (arready),      .in_data  (ar_in),
    .out_valid (mmio_arvalid), .out_ready  (mmio_arready), .out_data (ar_out)
  );

  //--------------------------------------------------------------------
  // Response half, bank to shell
  //--------------------------------------------------------------------
  assign b_in.resp  = mmio_bresp;
  assign r_in.data  = mmio_rdata;
  assign r_in.resp  = mmio_rresp;
  assign bresp      = b_out.resp;
  assign rdata      = r_out.data;
  assign rresp      = r_out.resp;

  axil_chan_buf #(.payload_t(axil_b_t)) b_buf_inst (
    .clk       (clk),          .sync_rst_n (sync_rst_n),
    .in_valid  (mmio_bvalid),  .in_ready   (mmio_bready),  .in_data  (b_in),
    .out_valid (bvalid),       .out_ready  (bready),       .out_data (b_out)
  );

  axil_chan_buf #(.payload_t(axil_r_t)) r_buf_inst (
    .clk       (clk),          .sync_rst_n (sync_rst_n),
    .in_valid  (mmio_rvalid),  .in_ready   (mmio_rready),  .in_data  (r_in),
    .out_valid (rvalid),       .out_ready  (rready),       .out_data (r_out)
  );

endmodule

//--- rtl/arrow_mmio_regs.sv
//----------------------------------------------------------------------
// MMIO register bank with ID words, scratch words and error responses
//----------------------------------------------------------------------
`timescale 1ns/10ps

module arrow_mmio_regs
  import arrow_pkg::*;
(
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   mmio_awvalid,
  output logic                   mmio_awready,
  input  logic [axil_addr_w-1:0] mmio_awaddr,
  input  logic                   mmio_wvalid,
  output logic                   mmio_wready,
  input  logic [axil_data_w-1:0] mmio_wdata,
  input  logic [axil_strb_w-1:0] mmio_wstrb,
  output logic                   mmio_bvalid,
  input  logic                   mmio_bready,
  output logic [1:0]             mmio_bresp,
  input  logic                   mmio_arvalid,
  output logic                   mmio_arready,
  input  logic [axil_addr_w-1:0] mmio_araddr,
  output logic                   mmio_rvalid,
  input  logic                   mmio_rready,
  output logic [axil_data_w-1:0] mmio_rdata,
  output logic [1:0]             mmio_rresp
);

  logic [axil_data_w-1:0]   scratch [scratch_count];
  logic                     wr_en, rd_en;
  logic [scratch_idx_w-1:0] wr_idx, rd_idx;
  axil_b_t                  b_q;
  axil_r_t                  r_q, r_nxt;

  // Offsets below the scratch base wrap high and miss
  function automatic logic scratch_hit(input axil_aw_t a);
    logic [axil_addr_w-1:0] off;
    off = a.addr - reg_scratch_base;
    return off < axil_addr_w'(scratch_count * 4);
  endfunction

  function automatic logic [scratch_idx_w-1:0] scratch_idx(input axil_aw_t a);
    logic [axil_addr_w-1:0] off;
    off = a.addr - reg_scratch_base;
    return off[scratch_idx_w+1:2];
  endfunction

  function automatic logic word_match(input axil_aw_t a, input logic [axil_addr_w-1:0] ref_addr);
    return a.addr[axil_addr_w-1:2] == ref_addr[axil_addr_w-1:2];
  endfunction

  // One write or read in flight per direction
  assign wr_en        = mmio_awvalid && mmio_wvalid && !mmio_bvalid;
  assign rd_en        = mmio_arvalid && !mmio_rvalid;
  assign mmio_awready = wr_en;
  assign mmio_wready  = wr_en;
  assign mmio_arready = rd_en;
  assign wr_idx       = scratch_idx(mmio_awaddr);
  assign rd_idx       = scratch_idx(mmio_araddr);

  //--------------------------------------------------------------------
  // Read decode
  //--------------------------------------------------------------------
  always_comb
  begin
    r_nxt.data = '0;
    r_nxt.resp = resp_okay;
    if (word_match(mmio_araddr, reg_id0_addr))
      r_nxt.data = cl_sh_id0_val;
    else if (word_match(mmio_araddr, reg_id1_addr))
      r_nxt.data = cl_sh_id1_val;
    else if (scratch_hit(mmio_araddr))
      r_nxt.data = scratch[rd_idx];
    else
      r_nxt.resp = resp_slverr;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      scratch     <= '{default: '0};
      mmio_bvalid <= 1'b0;
      mmio_rvalid <= 1'b0;
    end
    else
    begin
      if (wr_en)
      begin
        mmio_bvalid <= 1'b1;
        // Byte lanes update only where the strobe is set
        if (scratch_hit(mmio_awaddr))
          for (int b = 0; b < axil_strb_w; b++)
            if (mmio_wstrb[b])
              scratch[wr_idx][8*b +: 8] <= mmio_wdata[8*b +: 8];
      end
      else if (mmio_bready)
        mmio_bvalid <= 1'b0;

      if (rd_en)
        mmio_rvalid <= 1'b1;
      else if (mmio_rready)
        mmio_rvalid <= 1'b0;
    end
  end

  // Response payloads, held until the handshake
  always_ff @(posedge clk)
  begin
    if (wr_en)
      b_q.resp <= scratch_hit(mmio_awaddr) ? resp_okay : resp_slverr;
    if (rd_en)
      r_q <= r_nxt;
  end

  assign mmio_bresp = b_q.resp;
  assign mmio_rdata = r_q.data;
  assign mmio_rresp = r_q.resp;

endmodule

//--- rtl/cl_arrow.sv
//----------------------------------------------------------------------
// Custom logic top with reset block, BAR1 slice and register bank
//----------------------------------------------------------------------
`timescale 1ns/10ps

module cl_arrow
  import arrow_pkg::*;
(
  input  logic                   clk,
  input  logic                   pipe_rst_n,
  input  logic                   flr_assert,
  output logic                   flr_done,
  output logic [31:0]            cl_sh_id0,
  output logic [31:0]            cl_sh_id1,
  // BAR1 AXI4-Lite slave
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [axil_addr_w-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [axil_data_w-1:0] wdata,
  input  logic [axil_strb_w-1:0] wstrb,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [axil_addr_w-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [axil_data_w-1:0] rdata,
  output logic [1:0]             rresp
);

  logic                   sync_rst_n;
  logic                   mmio_awvalid, mmio_awready;
  logic [axil_addr_w-1:0] mmio_awaddr;
  logic                   mmio_wvalid, mmio_wready;
  logic [axil_data_w-1:0] mmio_wdata;
  logic [axil_strb_w-1:0] mmio_wstrb;
  logic                   mmio_bvalid, mmio_bready;
  logic [1:0]             mmio_bresp;
  logic                   mmio_arvalid, mmio_arready;
  logic [axil_addr_w-1:0] mmio_araddr;
  logic                   mmio_rvalid, mmio_rready;
  logic [axil_data_w-1:0] mmio_rdata;
  logic [1:0]             mmio_rresp;

  assign cl_sh_id0 = cl_sh_id0_val;
  assign cl_sh_id1 = cl_sh_id1_val;

  arrow_rst_sync rst_sync_inst (
    .clk        (clk),
    .pipe_rst_n (pipe_rst_n),
    .flr_assert (flr_assert),
    .sync_rst_n (sync_rst_n),
    .flr_done   (flr_done)
  );

  // Same-name connections on both sides of the slice
  arrow_bar1_slice bar1_slice_inst (.*);

  arrow_mmio_regs mmio_regs_inst (.*);

endmodule

//--- tb/cl_arrow_chk.sv
//----------------------------------------------------------------------
// Bound checks on top-level AXI4-Lite responses during and after reset
//----------------------------------------------------------------------
`timescale 1ns/10ps

module cl_arrow_chk (
  input logic        clk,
  input logic        sync_rst_n,
  input logic        bvalid,
  input logic        bready,
  input logic [1:0]  bresp,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata
);

  // Responses hold until accepted
  b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // Buffers clear on the edge after sync_rst_n falls
  rst_quiet: assert property (@(posedge clk)
    !sync_rst_n && !$past(sync_rst_n) |-> !bvalid && !rvalid)
    else $error("response valid while sync_rst_n low");

endmodule

bind cl_arrow cl_arrow_chk cl_arrow_chk_inst (
  .clk        (clk),
  .sync_rst_n (sync_rst_n),
  .bvalid     (bvalid),
  .bready     (bready),
  .bresp      (bresp),
  .rvalid     (rvalid),
  .rready     (rready),
  .rdata      (rdata)
);

//--- tb/tb_cl_arrow.sv
//----------------------------------------------------------------------
// Directed testbench for cl_arrow with AXI4-Lite driver tasks and checks
//----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_cl_arrow
  import arrow_pkg::*;
();

  // Tests take roughly 300 cycles, the limit leaves ample margin
  localparam int          timeout_cycles = 2000;
  localparam int          bp_hold_cycles = 20;
  localparam logic [31:0] rng_seed       = 32'd52249;

  logic                   clk, pipe_rst_n, flr_assert, flr_done;
  logic [31:0]            cl_sh_id0, cl_sh_id1;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;
  logic                   arvalid, arready, rvalid, rready;
  logic [axil_addr_w-1:0] awaddr, araddr;
  logic [axil_data_w-1:0] wdata, rdata;
  logic [axil_strb_w-1:0] wstrb;
  logic [1:0]             bresp, rresp;

  int          cycle_cnt;
  int          err_cnt, tests_ok, tests_bad;
  logic [31:0] rng_state;
  logic [31:0] model [scratch_count];

  cl_arrow cl_arrow_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", timeout_cycles);
    $display("Some tests failed");
    $finish;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    return res;
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return reg_scratch_base + 32'(4 * idx);
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      err_cnt++;
      $display("FAIL t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  //--------------------------------------------------------------------
  // AXI4-Lite driver, handshakes sampled between edges
  //--------------------------------------------------------------------
  task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic aw_hs, w_hs;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    while (awvalid || wvalid)
    begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge clk);
      #0.5;
      if (aw_hs)
        awvalid = 1'b0;
      if (w_hs)
        wvalid = 1'b0;
    end
  endtask

  task automatic wait_bresp(output logic [1:0] resp);
    logic hs;
    hs = 1'b0;
    while (!hs)
    begin
      hs   = bvalid && bready;
      resp = bresp;
      @(posedge clk);
      #0.5;
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    send_write(addr, data, strb);
    wait_bresp(resp);
  endtask

  task automatic send_read(input logic [31:0] addr);
    logic hs;
    araddr  = addr;
    arvalid = 1'b1;
    while (arvalid)
    begin
      hs = arvalid && arready;
      @(posedge clk);
      #0.5;
      if (hs)
        arvalid = 1'b0;
    end
  endtask

  task automatic wait_rresp(output logic [31:0] data, output logic [1:0] resp);
    logic hs;
    hs = 1'b0;
    while (!hs)
    begin
      hs   = rvalid && rready;
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #0.5;
    end
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    send_read(addr);
    wait_rresp(data, resp);
  endtask

  //--------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------
  task automatic test_reset_ids();
    int          errs;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = err_cnt;
    check("bvalid", 0, 32'(bvalid));
    check("rvalid", 0, 32'(rvalid));
    check("flr_done", 0, 32'(flr_done));
    // Still inside the sync chain delay
    check("awready", 0, 32'(awready));
    check("wready", 0, 32'(wready));
    check("arready", 0, 32'(arready));
    check("cl_sh_id0", cl_sh_id0_val, cl_sh_id0);
    check("cl_sh_id1", cl_sh_id1_val, cl_sh_id1);
    axil_read(reg_id0_addr, data, resp);
    check("rdata id0", cl_sh_id0_val, data);
    check("rresp id0", 32'(resp_okay), 32'(resp));
    axil_read(reg_id1_addr, data, resp);
    check("rdata id1", cl_sh_id1_val, data);
    check("rresp id1", 32'(resp_okay), 32'(resp));
    end_test("reset_ids", errs);
  endtask

  task automatic test_scratch();
    int          errs;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = err_cnt;
    for (int i = 0; i < scratch_count; i++)
    begin
      axil_read(word_addr(i), data, resp);
      check("rdata scratch after reset", 0, data);
    end
    for (int i = 0; i < scratch_count; i++)
    begin
      rng_state = xorshift(rng_state);
      model[i]  = rng_state;
      axil_write(word_addr(i), model[i], 4'hF, resp);
      check("bresp scratch", 32'(resp_okay), 32'(resp));
    end
    for (int i = 0; i < scratch_count; i++)
    begin
      axil_read(word_addr(i), data, resp);
      check("rdata scratch", model[i], data);
      check("rresp scratch", 32'(resp_okay), 32'(resp));
    end
    end_test("scratch", errs);
  endtask

  task automatic test_strobes();
    int          errs, idx;
    logic [3:0]  strb;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = err_cnt;
    for (int k = 0; k < 2; k++)
    begin
      idx       = (k == 0) ? 2 : 1;
      strb      = (k == 0) ? 4'b0101 : 4'b1000;
      rng_state = xorshift(rng_state);
      axil_write(word_addr(idx), rng_state, strb, resp);
      model[idx] = merge_bytes(model[idx], rng_state, strb);
      check("bresp strobe", 32'(resp_okay), 32'(resp));
      axil_read(word_addr(idx), data, resp);
      check("rdata strobe", model[idx], data);
    end
    end_test("strobes", errs);
  endtask

  task automatic test_errors();
    int          errs;
    logic [31:0] data;
    logic [1:0]  resp;
    errs = err_cnt;
    axil_write(reg_id0_addr, 32'hDEAD_BEEF, 4'hF, resp);
    check("bresp id0 write", 32'(resp_slverr), 32'(resp));
    axil_read(reg_id0_addr, data, resp);
    check("rdata id0 after write", cl_sh_id0_val, data);
    check("rresp id0 after write", 32'(resp_okay), 32'(resp));
    axil_read(32'h0000_0040, data, resp);
    check("rdata unmapped", 0, data);
    check("rresp unmapped", 32'(resp_slverr), 32'(resp));
    end_test("errors", errs);
  endtask

  task automatic test_backpressure();
    int          errs, hold_end;
    logic [31:0] data;
    logic [1:0]  resp;
    errs     = err_cnt;
    bready   = 1'b0;
    hold_end = cycle_cnt + bp_hold_cycles;
    // Word 0 is written twice, the read must see the second value
    for (int k = 0; k < 4; k++)
    begin
      rng_state     = xorshift(rng_state);
      model[k % 3]  = rng_state;
      send_write(word_addr(k % 3), rng_state, 4'hF);
    end
    while (cycle_cnt < hold_end)
    begin
      @(posedge clk);
      #0.5;
    end
    check("bvalid during hold", 1, 32'(bvalid));
    bready = 1'b1;
    for (int k = 0; k < 4; k++)
    begin
      wait_bresp(resp);
      check("bresp backpressure", 32'(resp_okay), 32'(resp));
    end
    // Read response parked in the slice until rready returns
    rready = 1'b0;
    send_read(word_addr(0));
    repeat (5)
    begin
      @(posedge clk);
      #0.5;
    end
    check("rvalid during hold", 1, 32'(rvalid));
    rready = 1'b1;
    wait_rresp(data, resp);
    check("rdata held read", model[0], data);
    check("rresp held read", 32'(resp_okay), 32'(resp));
    for (int i = 0; i < 3; i++)
    begin
      axil_read(word_addr(i), data, resp);
      check("rdata backpressure", model[i], data);
    end
    end_test("backpressure", errs);
  endtask

  task automatic test_flr();
    int errs, pulses, first_at;
    errs       = err_cnt;
    pulses     = 0;
    first_at   = -1;
    flr_assert = 1'b1;
    // Edges counted from the one that samples the request
    for (int i = 1; i <= 8; i++)
    begin
      @(posedge clk);
      #0.5;
      if (i == 1)
        flr_assert = 1'b0;
      if (flr_done)
      begin
        pulses++;
        if (first_at < 0)
          first_at = i;
      end
    end
    check("flr_done pulse count", 1, 32'(pulses));
    check("flr_done edge", 2, 32'(first_at));
    end_test("flr", errs);
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial
  begin
    pipe_rst_n = 1'b0;
    flr_assert = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    bready     = 1'b1;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b1;
    err_cnt    = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    rng_state  = rng_seed;
    for (int i = 0; i < scratch_count; i++)
      model[i] = '0;
    repeat (10) @(posedge clk);
    #0.5;
    pipe_rst_n = 1'b1;
    test_reset_ids();
    test_scratch();
    test_strobes();
    test_errors();
    test_backpressure();
    test_flr();
    $display("Summary: %0d passed, %0d failed, %0d mismatches", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- arrow_shell.f
rtl/arrow_pkg.sv
rtl/arrow_rst_sync.sv
rtl/axil_chan_buf.sv
rtl/arrow_bar1_slice.sv
rtl/arrow_mmio_regs.sv
rtl/cl_arrow.sv
tb/cl_arrow_chk.sv
tb/tb_cl_arrow.sv

//--- run.sh
#!/bin/sh
# Compile and run the arrow_shell testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_cl_arrow \
  -f arrow_shell.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation FAILED, run did not complete"; exit 1; }
echo "Simulation PASSED"
